/* verilog/mem_tile_pkg.sv */
// Widths and defaults for the banked memory tile.
// SramDataWidthDefault must divide WideDataWidth, and all sizes are powers of two.
// The defaults give at least two macro rows, so the row select is never zero bits wide.

`default_nettype none

package mem_tile_pkg;

  ////////////////////
  // tile word
  ////////////////////

  // one request moves a whole tile word
  localparam int unsigned WideDataWidth = 128;

  // one strobe per byte
  localparam int unsigned WideStrbWidth = WideDataWidth / 8;

  ////////////////////
  // tile capacity
  ////////////////////

  // capacity in bytes
  localparam int unsigned MemTileSize = 4096;

  // byte address, covers the whole tile
  localparam int unsigned MemAddrWidth = $clog2(MemTileSize);

  ////////////////////
  // macro defaults
  ////////////////////

  // width of one macro, a tile word spans several of these
  localparam int unsigned SramDataWidthDefault = 64;

  // depth of one macro in words
  localparam int unsigned SramNumWordsDefault = 64;

  ////////////////////
  // types
  ////////////////////

  // tile word and its byte strobes
  typedef logic [WideDataWidth-1:0] wide_data_t;
  typedef logic [WideStrbWidth-1:0] wide_strb_t;

  // byte address into the tile
  typedef logic [MemAddrWidth-1:0] mem_addr_t;

endpackage

`default_nettype wire

/* verilog/mem_req_stage.sv */
// Request register in front of the macros. One request per cycle, never refused.
// Byte-offset bits of addr_i are ignored, so every access is word aligned.
// Address layout from the LSB: byte offset, word in macro, macro row.

`timescale 1ns/10ps
`default_nettype none

module mem_req_stage #(
  parameter  int unsigned SramDataWidth   = mem_tile_pkg::SramDataWidthDefault,
  parameter  int unsigned SramNumWords    = mem_tile_pkg::SramNumWordsDefault,
  localparam int unsigned NumBanksPerWord = mem_tile_pkg::WideDataWidth / SramDataWidth,
  localparam int unsigned NumBankRows     =
    (mem_tile_pkg::MemTileSize / mem_tile_pkg::WideStrbWidth) / SramNumWords,
  localparam int unsigned SramAddrWidth   = $clog2(SramNumWords),
  localparam int unsigned RowSelWidth     = $clog2(NumBankRows),
  localparam int unsigned SramStrbWidth   = SramDataWidth / 8
) (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         req_i,
  input  logic                                         we_i,
  input  mem_tile_pkg::mem_addr_t                      addr_i,
  input  mem_tile_pkg::wide_data_t                     wdata_i,
  input  mem_tile_pkg::wide_strb_t                     be_i,
  output logic                                         bank_req_o,
  output logic                                         bank_we_o,
  output logic [SramAddrWidth-1:0]                     word_addr_o,
  output logic [RowSelWidth-1:0]                       row_sel_o,
  output logic [NumBanksPerWord-1:0][SramDataWidth-1:0] bank_wdata_o,
  output logic [NumBanksPerWord-1:0][SramStrbWidth-1:0] bank_be_o,
  output logic                                         rd_pending_o
);

  import mem_tile_pkg::*;

  // address field offsets
  localparam int unsigned ByteOffsetWidth = $clog2(WideStrbWidth);
  localparam int unsigned WordAddrOffset  = ByteOffsetWidth;
  localparam int unsigned RowSelOffset    = WordAddrOffset + SramAddrWidth;

  logic                     req_q;
  logic                     rd_q;
  logic                     we_q;
  logic [SramAddrWidth-1:0] word_addr_q;
  logic [RowSelWidth-1:0]   row_sel_q;
  wide_data_t               wdata_q;
  wide_strb_t               be_q;

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q <= 1'b0;
      rd_q  <= 1'b0;
    end else begin
      req_q <= req_i;
      rd_q  <= req_i & ~we_i;
    end
  end

  ////////////////////
  // payload
  ////////////////////

  // only captured with a request, holds otherwise
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      we_q        <= we_i;
      word_addr_q <= addr_i[WordAddrOffset +: SramAddrWidth];
      row_sel_q   <= addr_i[RowSelOffset +: RowSelWidth];
      wdata_q     <= wdata_i;
      be_q        <= be_i;
    end
  end

  // slice the wide word over the banks, bank 0 takes the low bits
  for (genvar b = 0; b < NumBanksPerWord; b++) begin : gen_bank_slice
    assign bank_wdata_o[b] = wdata_q[b*SramDataWidth +: SramDataWidth];
    assign bank_be_o[b]    = be_q[b*SramStrbWidth +: SramStrbWidth];
  end

  assign bank_req_o   = req_q;
  assign bank_we_o    = we_q;
  assign word_addr_o  = word_addr_q;
  assign row_sel_o    = row_sel_q;
  assign rd_pending_o = rd_q;

endmodule

`default_nettype wire

/* verilog/sram_bank_array.sv */
// Behavioral single-port macros, rows by banks, one cycle read latency.
// Contents are not reset and start unknown in simulation.
// A write also returns the old word at that address on the read output.

`timescale 1ns/10ps
`default_nettype none

module sram_bank_array #(
  parameter  int unsigned SramDataWidth   = mem_tile_pkg::SramDataWidthDefault,
  parameter  int unsigned SramNumWords    = mem_tile_pkg::SramNumWordsDefault,
  localparam int unsigned NumBanksPerWord = mem_tile_pkg::WideDataWidth / SramDataWidth,
  localparam int unsigned NumBankRows     =
    (mem_tile_pkg::MemTileSize / mem_tile_pkg::WideStrbWidth) / SramNumWords,
  localparam int unsigned SramAddrWidth   = $clog2(SramNumWords),
  localparam int unsigned RowSelWidth     = $clog2(NumBankRows),
  localparam int unsigned SramStrbWidth   = SramDataWidth / 8
) (
  input  logic                                         clk_i,
  input  logic                                         bank_req_i,
  input  logic                                         bank_we_i,
  input  logic [SramAddrWidth-1:0]                     word_addr_i,
  input  logic [RowSelWidth-1:0]                       row_sel_i,
  input  logic [NumBanksPerWord-1:0][SramDataWidth-1:0] bank_wdata_i,
  input  logic [NumBanksPerWord-1:0][SramStrbWidth-1:0] bank_be_i,
  output logic [NumBankRows-1:0][NumBanksPerWord-1:0][SramDataWidth-1:0] macro_rdata_o
);

  ////////////////////
  // row decode
  ////////////////////

  // one hot, only the addressed row sees the request
  logic [NumBankRows-1:0] row_en;

  for (genvar r = 0; r < NumBankRows; r++) begin : gen_row_en
    assign row_en[r] = bank_req_i && (row_sel_i == RowSelWidth'(r));
  end

  ////////////////////
  // macros
  ////////////////////

  for (genvar r = 0; r < NumBankRows; r++) begin : gen_rows
    for (genvar b = 0; b < NumBanksPerWord; b++) begin : gen_banks

      logic [SramDataWidth-1:0] mem_q [SramNumWords];
      logic [SramDataWidth-1:0] rdata_q;

      // byte-enabled write, masked bytes keep their value
      always_ff @(posedge clk_i) begin
        if (row_en[r] && bank_we_i) begin
          for (int unsigned i = 0; i < SramStrbWidth; i++) begin
            if (bank_be_i[b][i]) begin
              mem_q[word_addr_i][i*8 +: 8] <= bank_wdata_i[b][i*8 +: 8];
            end
          end
        end
      end

      // read port, old data on a write
      always_ff @(posedge clk_i) begin
        if (row_en[r]) begin
          rdata_q <= mem_q[word_addr_i];
        end
      end

      assign macro_rdata_o[r][b] = rdata_q;

    end
  end

endmodule

`default_nettype wire

/* verilog/rdata_select.sv */
// Response side of the tile. rvalid_o pulses once per request, reads and writes alike.
// rdata_o is only meaningful when rvalid_o answers a read.

`timescale 1ns/10ps
`default_nettype none

module rdata_select #(
  parameter  int unsigned SramDataWidth   = mem_tile_pkg::SramDataWidthDefault,
  parameter  int unsigned SramNumWords    = mem_tile_pkg::SramNumWordsDefault,
  localparam int unsigned NumBanksPerWord = mem_tile_pkg::WideDataWidth / SramDataWidth,
  localparam int unsigned NumBankRows     =
    (mem_tile_pkg::MemTileSize / mem_tile_pkg::WideStrbWidth) / SramNumWords,
  localparam int unsigned RowSelWidth     = $clog2(NumBankRows)
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     bank_req_i,
  input  logic                     rd_pending_i,
  input  logic [RowSelWidth-1:0]   row_sel_i,
  input  logic [NumBankRows-1:0][NumBanksPerWord-1:0][SramDataWidth-1:0] macro_rdata_i,
  output logic                     rvalid_o,
  output mem_tile_pkg::wide_data_t rdata_o
);

  logic                   rvalid_q;
  logic [RowSelWidth-1:0] row_sel_q;

  ////////////////////
  // response control
  ////////////////////

  // same edge as the macro read
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q  <= 1'b0;
      row_sel_q <= '0;
    end else begin
      rvalid_q <= bank_req_i;
      // writes leave the select alone, it keeps pointing at the last read row
      if (rd_pending_i) begin
        row_sel_q <= row_sel_i;
      end
    end
  end

  ////////////////////
  // read data
  ////////////////////

  // each bank picks the macro that was actually read
  for (genvar b = 0; b < NumBanksPerWord; b++) begin : gen_rdata
    assign rdata_o[b*SramDataWidth +: SramDataWidth] = macro_rdata_i[row_sel_q][b];
  end

  assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

/* verilog/mem_tile.sv */
// Banked memory tile with one wide request port and fixed two cycle latency.
// No grant and no back-pressure: every request is accepted and answered in order.
// Low address bits below the tile word are ignored.

`timescale 1ns/10ps
`default_nettype none

module mem_tile #(
  parameter int unsigned SramDataWidth = mem_tile_pkg::SramDataWidthDefault,
  parameter int unsigned SramNumWords  = mem_tile_pkg::SramNumWordsDefault
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  mem_tile_pkg::mem_addr_t  addr_i,
  input  mem_tile_pkg::wide_data_t wdata_i,
  input  mem_tile_pkg::wide_strb_t be_i,
  output logic                     rvalid_o,
  output mem_tile_pkg::wide_data_t rdata_o
);

  import mem_tile_pkg::*;

  // banks side by side make one tile word
  localparam int unsigned NumBanksPerWord = WideDataWidth / SramDataWidth;
  // rows needed to hold the whole tile
  localparam int unsigned NumBankRows     = (MemTileSize / WideStrbWidth) / SramNumWords;
  localparam int unsigned SramAddrWidth   = $clog2(SramNumWords);
  localparam int unsigned RowSelWidth     = $clog2(NumBankRows);
  localparam int unsigned SramStrbWidth   = SramDataWidth / 8;

  logic                                          bank_req;
  logic                                          bank_we;
  logic                                          rd_pending;
  logic [SramAddrWidth-1:0]                      word_addr;
  logic [RowSelWidth-1:0]                        row_sel;
  logic [NumBanksPerWord-1:0][SramDataWidth-1:0] bank_wdata;
  logic [NumBanksPerWord-1:0][SramStrbWidth-1:0] bank_be;
  logic [NumBankRows-1:0][NumBanksPerWord-1:0][SramDataWidth-1:0] macro_rdata;

  ////////////////////
  // request
  ////////////////////

  mem_req_stage #(
    .SramDataWidth (SramDataWidth),
    .SramNumWords  (SramNumWords)
  ) i_req_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .word_addr_o  (word_addr),
    .row_sel_o    (row_sel),
    .bank_wdata_o (bank_wdata),
    .bank_be_o    (bank_be),
    .rd_pending_o (rd_pending)
  );

  ////////////////////
  // macros
  ////////////////////

  sram_bank_array #(
    .SramDataWidth (SramDataWidth),
    .SramNumWords  (SramNumWords)
  ) i_bank_array (
    .clk_i         (clk_i),
    .bank_req_i    (bank_req),
    .bank_we_i     (bank_we),
    .word_addr_i   (word_addr),
    .row_sel_i     (row_sel),
    .bank_wdata_i  (bank_wdata),
    .bank_be_i     (bank_be),
    .macro_rdata_o (macro_rdata)
  );

  ////////////////////
  // response
  ////////////////////

  rdata_select #(
    .SramDataWidth (SramDataWidth),
    .SramNumWords  (SramNumWords)
  ) i_rdata_select (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .bank_req_i    (bank_req),
    .rd_pending_i  (rd_pending),
    .row_sel_i     (row_sel),
    .macro_rdata_i (macro_rdata),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o)
  );

endmodule

`default_nettype wire

/* bench/mem_tile_chk.sv */
// Protocol checks on the tile ports, bound into every mem_tile instance.
// Assumes the fixed two cycle latency and no back-pressure.

`timescale 1ns/10ps
`default_nettype none

module mem_tile_chk (
  input logic clk_i,
  input logic rst_i,
  input logic req_i,
  input logic rvalid_i
);

  // failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  ////////////////////
  // response valid
  ////////////////////

  // never unknown once out of reset
  assert property (@(posedge clk_i) disable iff (rst_i) !$isunknown(rvalid_i))
    else begin
      fail_count++;
      $error("rvalid_o is unknown after reset");
    end

  // every request gets exactly one response, two edges later
  assert property (@(posedge clk_i) disable iff (rst_i) req_i |-> ##2 rvalid_i)
    else begin
      fail_count++;
      $error("request without a response two cycles later");
    end

  assert property (@(posedge clk_i) disable iff (rst_i) !req_i |-> ##2 !rvalid_i)
    else begin
      fail_count++;
      $error("response without a matching request");
    end

  // quiet during reset and in the two cycles after it
  assert property (@(posedge clk_i) rst_i |=> !rvalid_i ##1 !rvalid_i)
    else begin
      fail_count++;
      $error("rvalid_o raised during or right after reset");
    end

endmodule

bind mem_tile mem_tile_chk i_chk (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .req_i    (req_i),
  .rvalid_i (rvalid_o)
);

`default_nettype wire

/* bench/mem_tile_tb.sv */
// Testbench for the memory tile: directed phases, then xorshift random traffic.
// Expected responses come from a byte-wise memory model and a three-entry response pipeline.
// Every read targets a word already written, so no unknown data is compared.

`timescale 1ns/10ps
`default_nettype none

module mem_tile_tb;

  import mem_tile_pkg::*;

  localparam int unsigned ByteOffsetWidth = $clog2(WideStrbWidth);
  localparam int unsigned NumWords        = MemTileSize / WideStrbWidth;
  localparam int unsigned NumRandomReqs   = 2000;
  localparam int unsigned ResetCycles     = 4;
  localparam int unsigned DirectedCycles  = 64;
  // a response is sampled three edges after its request is driven
  localparam int unsigned ResponseDepth   = 3;
  // reset, directed, fill and readback, random traffic with about one idle in sixteen
  localparam int unsigned ExpectedCycles  =
    ResetCycles + DirectedCycles + 2 * NumWords + (NumRandomReqs * 17) / 16;
  localparam int unsigned TimeoutCycles   = ExpectedCycles + ExpectedCycles / 8;

  logic       clk;
  logic       rst;
  logic       req;
  logic       we;
  mem_addr_t  addr;
  wide_data_t wdata;
  wide_strb_t be;
  logic       rvalid;
  wide_data_t rdata;

  logic [31:0] rng_state;
  wide_data_t  model_mem [int unsigned];
  logic        exp_valid_q [$];
  logic        exp_read_q [$];
  wide_data_t  exp_data_q [$];
  int unsigned error_count;
  int unsigned check_count;
  int unsigned cycle_count;

  mem_tile #(
    .SramDataWidth (SramDataWidthDefault),
    .SramNumWords  (SramNumWordsDefault)
  ) i_dut (
    .clk_i    (clk),
    .rst_i    (rst),
    .req_i    (req),
    .we_i     (we),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .be_i     (be),
    .rvalid_o (rvalid),
    .rdata_o  (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // random numbers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic wide_data_t rand_wide();
    wide_data_t d;
    for (int i = 0; i < WideDataWidth / 32; i++) begin
      d[i*32 +: 32] = rand32();
    end
    return d;
  endfunction

  ////////////////////
  // model
  ////////////////////

  // bytes never written stay unknown, as in the macros
  function automatic void model_write(input int unsigned w, input wide_data_t d,
                                      input wide_strb_t s);
    wide_data_t cur;
    if (model_mem.exists(w)) begin
      cur = model_mem[w];
    end else begin
      cur = 'x;
    end
    for (int i = 0; i < WideStrbWidth; i++) begin
      if (s[i]) begin
        cur[i*8 +: 8] = d[i*8 +: 8];
      end
    end
    model_mem[w] = cur;
  endfunction

  function automatic wide_data_t model_read(input int unsigned w);
    wide_data_t d;
    if (model_mem.exists(w)) begin
      d = model_mem[w];
    end else begin
      d = 'x;
    end
    return d;
  endfunction

  ////////////////////
  // stimulus
  ////////////////////

  // one call per clock cycle, every cycle queues one expected response
  task automatic drive_cycle(input logic r, input logic w_en, input mem_addr_t a,
                             input wide_data_t d, input wide_strb_t s);
    int unsigned w;
    @(posedge clk);
    req   <= r;
    we    <= w_en;
    addr  <= a;
    wdata <= d;
    be    <= s;
    w = a >> ByteOffsetWidth;
    exp_valid_q.push_back(r);
    exp_read_q.push_back(r && !w_en);
    exp_data_q.push_back((r && !w_en) ? model_read(w) : '0);
    if (r && w_en) begin
      model_write(w, d, s);
    end
  endtask

  task automatic write_word(input mem_addr_t a, input wide_data_t d, input wide_strb_t s);
    drive_cycle(1'b1, 1'b1, a, d, s);
  endtask

  task automatic read_word(input mem_addr_t a);
    drive_cycle(1'b1, 1'b0, a, rand_wide(), '0);
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) drive_cycle(1'b0, 1'b0, '0, '0, '0);
  endtask

  ////////////////////
  // response check
  ////////////////////

  // outputs are stable at the falling edge
  always @(negedge clk) begin : check_response
    logic       ev;
    logic       er;
    wide_data_t ed;
    if (exp_valid_q.size() >= ResponseDepth) begin
      ev = exp_valid_q.pop_front();
      er = exp_read_q.pop_front();
      ed = exp_data_q.pop_front();
      check_count++;
      assert (rvalid === ev) else begin
        error_count++;
        $display("** Error at %0d ns: rvalid_o is %b, expected %b", $time, rvalid, ev);
      end
      if (ev && er) begin
        assert (rdata === ed) else begin
          error_count++;
          $display("** Error at %0d ns: rdata_o is %h, expected %h", $time, rdata, ed);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : stimulus
    mem_addr_t   a;
    mem_addr_t   last_addr;
    wide_data_t  d;
    logic [31:0] r;
    int unsigned issued;
    rng_state   = 32'h8ac0;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    rst   = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    be    = '0;
    idle_cycles(ResetCycles);
    rst <= 1'b0;
    idle_cycles(4);

    // full write then read back
    a = mem_addr_t'(rand32());
    write_word(a, rand_wide(), '1);
    read_word(a);
    idle_cycles(4);

    // byte strobes merge into one word
    a = mem_addr_t'(rand32());
    write_word(a, rand_wide(), '1);
    for (int i = 0; i < 8; i++) begin
      write_word(a, rand_wide(), wide_strb_t'(rand32()));
      if (i == 3) begin
        read_word(a);
      end
    end
    read_word(a);
    idle_cycles(4);

    // fill the tile in a scattered order, then read all of it back
    for (int unsigned i = 0; i < NumWords; i++) begin
      a = mem_addr_t'((((i * 37) % NumWords) << ByteOffsetWidth) | (rand32() % WideStrbWidth));
      write_word(a, rand_wide(), '1);
    end
    for (int unsigned i = 0; i < NumWords; i++) begin
      a = mem_addr_t'((((i * 101) % NumWords) << ByteOffsetWidth) | (rand32() % WideStrbWidth));
      read_word(a);
    end
    idle_cycles(4);

    // mixed traffic, sometimes hitting the previous address
    last_addr = '0;
    issued    = 0;
    while (issued < NumRandomReqs) begin
      r = rand32();
      if (r[3:0] == 4'h0) begin
        idle_cycles(1);
      end else begin
        a = (r[6:4] == 3'b000) ? last_addr : mem_addr_t'(rand32());
        d = rand_wide();
        if (r[8]) begin
          write_word(a, d, r[9] ? '1 : wide_strb_t'(rand32()));
        end else begin
          read_word(a);
        end
        last_addr = a;
        issued++;
      end
    end

    idle_cycles(ResponseDepth);
    @(negedge clk);
    #1;
    $display("run ended: %0d responses checked, %0d errors, %0d assertion failures",
             check_count, error_count, i_dut.i_chk.fail_count);
    if (error_count == 0 && i_dut.i_chk.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/mem_tile_pkg.sv
verilog/mem_req_stage.sv
verilog/sram_bank_array.sv
verilog/rdata_select.sv
verilog/mem_tile.sv
bench/mem_tile_chk.sv
bench/mem_tile_tb.sv

/* Bender.yml */
package:
  name: mem_tile

dependencies: {}

sources:
  # tile RTL, package first
  - files:
      - verilog/mem_tile_pkg.sv
      - verilog/mem_req_stage.sv
      - verilog/sram_bank_array.sv
      - verilog/rdata_select.sv
      - verilog/mem_tile.sv

  # bound checks and testbench
  - target: any(simulation, test)
    files:
      - bench/mem_tile_chk.sv
      - bench/mem_tile_tb.sv
